// ==== fetch_pkg.sv ====
package fetch_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] inst_t;
	typedef logic [6:0] opcode_t;
	typedef logic [2:0] funct3_t;
	typedef logic [4:0] reg_idx_t;

	localparam addr_t INIT_PC = 32'h0000_0000;
	localparam int IMEM_WORDS = 64;

	// Major opcodes, RV32I base encoding
	localparam opcode_t OPC_BRANCH = 7'b1100011;
	localparam opcode_t OPC_JAL = 7'b1101111;
	localparam opcode_t OPC_JALR = 7'b1100111;

	// Branch conditions in funct3
	localparam funct3_t F3_BEQ = 3'b000;
	localparam funct3_t F3_BNE = 3'b001;
	localparam funct3_t F3_BLT = 3'b100;
	localparam funct3_t F3_BGE = 3'b101;
	localparam funct3_t F3_BLTU = 3'b110;
	localparam funct3_t F3_BGEU = 3'b111;

endpackage

// ==== apb_read_master.sv ====
`timescale 1ns/1ps

module apb_read_master
	import fetch_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  start_i,
	input  addr_t addr_i,
	output logic  busy_o,
	output logic  done_o,
	output inst_t rdata_o,
	output logic  psel_o,
	output logic  penable_o,
	output addr_t paddr_o,
	input  logic  pready_i,
	input  inst_t prdata_i
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SETUP,
		ST_ACCESS
	} apb_state_t;

	apb_state_t state;
	addr_t addr_q;
	inst_t rdata_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			done_o <= 1'b0;
		end else begin
			done_o <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (start_i) begin
						state <= ST_SETUP;
					end
				end
				ST_SETUP: begin
					state <= ST_ACCESS;
				end
				ST_ACCESS: begin
					if (pready_i) begin
						state <= ST_IDLE;
						done_o <= 1'b1;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// Address and read data carry no reset
	always_ff @(posedge clk) begin
		if (state == ST_IDLE && start_i) begin
			addr_q <= addr_i;
		end
		if (state == ST_ACCESS && pready_i) begin
			rdata_q <= prdata_i;
		end
	end

	assign busy_o = (state != ST_IDLE);
	assign psel_o = (state == ST_SETUP) || (state == ST_ACCESS);
	assign penable_o = (state == ST_ACCESS);
	assign paddr_o = addr_q;
	assign rdata_o = rdata_q;

	a_paddr_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(penable_o && !pready_i) |=> $stable(paddr_o));

endmodule

// ==== imem_apb.sv ====
`timescale 1ns/1ps

module imem_apb
	import fetch_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  psel_i,
	input  logic  penable_i,
	input  addr_t paddr_i,
	output logic  pready_o,
	output inst_t prdata_o
);

	inst_t mem [IMEM_WORDS];
	logic [1:0] wait_cnt;
	logic access;
	logic [5:0] word_idx;

	initial begin
		$readmemh("program.hex", mem);
	end

	assign access = psel_i && penable_i;
	assign word_idx = paddr_i[7:2];

	// Wait states follow address bits 3:2
	assign pready_o = access && (wait_cnt == paddr_i[3:2]);
	assign prdata_o = mem[word_idx];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wait_cnt <= '0;
		end else if (access && !pready_o) begin
			wait_cnt <= wait_cnt + 2'd1;
		end else begin
			wait_cnt <= '0;
		end
	end

	a_addr_in_range: assert property (@(posedge clk) disable iff (!rst_n)
		psel_i |-> (paddr_i[31:2] < IMEM_WORDS));

endmodule

// ==== fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit
	import fetch_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	output logic  valid_o,
	output addr_t pc_o,
	output inst_t inst_o,
	output logic  pred_taken_o,
	input  logic  ready_i,
	input  logic  jmp_i,
	input  logic  branch_i,
	input  addr_t target_i,
	input  logic  cmp_valid_i,
	input  logic  cmp_taken_i,
	output logic  start_o,
	output addr_t addr_o,
	input  logic  busy_i,
	input  logic  done_i,
	input  inst_t rdata_i
);

	typedef enum logic [2:0] {
		ST_INIT_FETCH,
		ST_FETCH,
		ST_INIT_FETCH_SPEC,
		ST_FETCH_SPEC,
		ST_DISCARD,
		ST_FULL_BUFFER,
		ST_FULL_BUFFER_SPEC
	} fetch_state_t;

	fetch_state_t state;
	fetch_state_t xfer_state;
	addr_t pc_q;
	addr_t alt_q;
	logic pred_q;
	inst_t buf_q;
	addr_t pc_plus4;
	addr_t next_pc;
	logic presenting;
	logic xfer;
	logic mispredict;

	assign pc_plus4 = pc_q + 32'd4;

	// pc_q holds the address of the word in flight or presented
	assign presenting = (state == ST_FETCH) || (state == ST_FULL_BUFFER);
	assign valid_o = (state == ST_FETCH) ? done_i : (state == ST_FULL_BUFFER);
	assign inst_o = (state == ST_FETCH) ? rdata_i : buf_q;
	assign pc_o = pc_q;

	// Backward branches predicted taken
	assign pred_taken_o = (inst_o[6:0] == OPC_BRANCH) && inst_o[31];

	assign xfer = valid_o && ready_i;
	assign mispredict = cmp_valid_i && (cmp_taken_i != pred_q);

	always_comb begin
		if (jmp_i || (branch_i && pred_taken_o)) begin
			next_pc = target_i;
		end else begin
			next_pc = pc_plus4;
		end
	end

	// Where an accepted instruction sends the FSM
	always_comb begin
		if (busy_i) begin
			xfer_state = branch_i ? ST_INIT_FETCH_SPEC : ST_INIT_FETCH;
		end else begin
			xfer_state = branch_i ? ST_FETCH_SPEC : ST_FETCH;
		end
	end

	always_comb begin
		case (state)
			ST_INIT_FETCH: start_o = !busy_i;
			ST_INIT_FETCH_SPEC: start_o = !busy_i && !mispredict;
			ST_FETCH, ST_FULL_BUFFER: start_o = xfer && !busy_i;
			default: start_o = 1'b0;
		endcase
	end

	assign addr_o = presenting ? next_pc : pc_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_INIT_FETCH;
			pc_q <= INIT_PC;
			alt_q <= INIT_PC;
			pred_q <= 1'b0;
		end else begin
			if (xfer) begin
				pc_q <= next_pc;
				if (branch_i) begin
					alt_q <= pred_taken_o ? pc_plus4 : target_i;
					pred_q <= pred_taken_o;
				end
			end
			case (state)
				ST_INIT_FETCH: begin
					if (!busy_i) begin
						state <= ST_FETCH;
					end
				end
				ST_INIT_FETCH_SPEC: begin
					if (mispredict) begin
						pc_q <= alt_q;
						state <= ST_INIT_FETCH;
					end else if (cmp_valid_i) begin
						state <= busy_i ? ST_INIT_FETCH : ST_FETCH;
					end else if (!busy_i) begin
						state <= ST_FETCH_SPEC;
					end
				end
				ST_FETCH: begin
					if (xfer) begin
						state <= xfer_state;
					end else if (done_i) begin
						state <= ST_FULL_BUFFER;
					end
				end
				ST_FULL_BUFFER: begin
					if (xfer) begin
						state <= xfer_state;
					end
				end
				ST_FETCH_SPEC: begin
					if (mispredict) begin
						pc_q <= alt_q;
						// A read still in flight must finish first
						state <= done_i ? ST_INIT_FETCH : ST_DISCARD;
					end else if (cmp_valid_i) begin
						state <= done_i ? ST_FULL_BUFFER : ST_FETCH;
					end else if (done_i) begin
						state <= ST_FULL_BUFFER_SPEC;
					end
				end
				ST_FULL_BUFFER_SPEC: begin
					if (mispredict) begin
						pc_q <= alt_q;
						state <= ST_INIT_FETCH;
					end else if (cmp_valid_i) begin
						state <= ST_FULL_BUFFER;
					end
				end
				ST_DISCARD: begin
					if (done_i) begin
						state <= ST_INIT_FETCH;
					end
				end
				default: begin
					state <= ST_INIT_FETCH;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (done_i) begin
			buf_q <= rdata_i;
		end
	end

	a_no_valid_in_discard: assert property (@(posedge clk) disable iff (!rst_n)
		(state == ST_DISCARD) |-> !valid_o);

endmodule

// ==== branch_resolver.sv ====
`timescale 1ns/1ps

module branch_resolver
	import fetch_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  f_valid_i,
	input  addr_t f_pc_i,
	input  inst_t f_inst_i,
	input  logic  f_pred_taken_i,
	output logic  ready_o,
	output logic  jmp_o,
	output logic  branch_o,
	output addr_t target_o,
	output logic  cmp_valid_o,
	output logic  cmp_taken_o,
	output logic  retire_valid_o,
	output addr_t retire_pc_o,
	output inst_t retire_inst_o,
	input  logic  retire_ready_i
);

	opcode_t opcode;
	funct3_t funct3;
	reg_idx_t rs1;
	reg_idx_t rs2;
	addr_t imm_b;
	addr_t imm_j;
	logic is_jal;
	logic is_branch;
	logic cond;
	logic xfer;

	assign opcode = f_inst_i[6:0];
	assign funct3 = f_inst_i[14:12];
	assign rs1 = f_inst_i[19:15];
	assign rs2 = f_inst_i[24:20];

	assign imm_b = {{19{f_inst_i[31]}}, f_inst_i[31], f_inst_i[7],
		f_inst_i[30:25], f_inst_i[11:8], 1'b0};
	assign imm_j = {{11{f_inst_i[31]}}, f_inst_i[31], f_inst_i[19:12],
		f_inst_i[20], f_inst_i[30:21], 1'b0};

	assign is_jal = (opcode == OPC_JAL);
	assign is_branch = (opcode == OPC_BRANCH);

	// No register file, so index fields stand in for operands
	always_comb begin
		case (funct3)
			F3_BEQ: cond = (rs1 == rs2);
			F3_BNE: cond = (rs1 != rs2);
			F3_BLT: cond = ($signed(rs1) < $signed(rs2));
			F3_BGE: cond = ($signed(rs1) >= $signed(rs2));
			F3_BLTU: cond = (rs1 < rs2);
			F3_BGEU: cond = (rs1 >= rs2);
			default: cond = 1'b0;
		endcase
	end

	// Stall while a branch awaits its answer or retire is blocked
	assign ready_o = !cmp_valid_o && (!retire_valid_o || retire_ready_i);
	assign xfer = f_valid_i && ready_o;

	assign jmp_o = xfer && is_jal;
	assign branch_o = xfer && is_branch;
	assign target_o = f_pc_i + (is_jal ? imm_j : imm_b);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cmp_valid_o <= 1'b0;
			cmp_taken_o <= 1'b0;
			retire_valid_o <= 1'b0;
		end else begin
			cmp_valid_o <= branch_o;
			if (branch_o) begin
				cmp_taken_o <= cond;
			end
			if (xfer) begin
				retire_valid_o <= 1'b1;
			end else if (retire_ready_i) begin
				retire_valid_o <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (xfer) begin
			retire_pc_o <= f_pc_i;
			retire_inst_o <= f_inst_i;
		end
	end

	a_cmp_single: assert property (@(posedge clk) disable iff (!rst_n)
		cmp_valid_o |=> !cmp_valid_o);

endmodule

// ==== fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top
	import fetch_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	output logic  retire_valid_o,
	output addr_t retire_pc_o,
	output inst_t retire_inst_o,
	input  logic  retire_ready_i
);

	logic f_valid;
	addr_t f_pc;
	inst_t f_inst;
	logic f_pred_taken;
	logic f_ready;
	logic jmp;
	logic branch;
	addr_t target;
	logic cmp_valid;
	logic cmp_taken;

	logic start;
	addr_t fetch_addr;
	logic busy;
	logic done;
	inst_t rdata;

	logic psel;
	logic penable;
	addr_t paddr;
	logic pready;
	inst_t prdata;

	fetch_unit u_fetch (
		.clk(clk),
		.rst_n(rst_n),
		.valid_o(f_valid),
		.pc_o(f_pc),
		.inst_o(f_inst),
		.pred_taken_o(f_pred_taken),
		.ready_i(f_ready),
		.jmp_i(jmp),
		.branch_i(branch),
		.target_i(target),
		.cmp_valid_i(cmp_valid),
		.cmp_taken_i(cmp_taken),
		.start_o(start),
		.addr_o(fetch_addr),
		.busy_i(busy),
		.done_i(done),
		.rdata_i(rdata)
	);

	apb_read_master u_apb_master (
		.clk(clk),
		.rst_n(rst_n),
		.start_i(start),
		.addr_i(fetch_addr),
		.busy_o(busy),
		.done_o(done),
		.rdata_o(rdata),
		.psel_o(psel),
		.penable_o(penable),
		.paddr_o(paddr),
		.pready_i(pready),
		.prdata_i(prdata)
	);

	imem_apb u_imem (
		.clk(clk),
		.rst_n(rst_n),
		.psel_i(psel),
		.penable_i(penable),
		.paddr_i(paddr),
		.pready_o(pready),
		.prdata_o(prdata)
	);

	branch_resolver u_resolver (
		.clk(clk),
		.rst_n(rst_n),
		.f_valid_i(f_valid),
		.f_pc_i(f_pc),
		.f_inst_i(f_inst),
		.f_pred_taken_i(f_pred_taken),
		.ready_o(f_ready),
		.jmp_o(jmp),
		.branch_o(branch),
		.target_o(target),
		.cmp_valid_o(cmp_valid),
		.cmp_taken_o(cmp_taken),
		.retire_valid_o(retire_valid_o),
		.retire_pc_o(retire_pc_o),
		.retire_inst_o(retire_inst_o),
		.retire_ready_i(retire_ready_i)
	);

endmodule

// ==== tb_fetch.sv ====
`timescale 1ns/1ps

module tb_fetch
	import fetch_pkg::*;
();

	localparam int RETIRE_COUNT = 60;
	localparam int TIMEOUT_CYCLES = 200;

	logic clk;
	logic rst_n;
	logic retire_valid;
	addr_t retire_pc;
	inst_t retire_inst;
	logic retire_ready;

	inst_t prog [IMEM_WORDS];

	// Stall tracking for the output stability check
	logic stalled;
	addr_t held_pc;
	inst_t held_inst;

	fetch_top DUT (
		.clk(clk),
		.rst_n(rst_n),
		.retire_valid_o(retire_valid),
		.retire_pc_o(retire_pc),
		.retire_inst_o(retire_inst),
		.retire_ready_i(retire_ready)
	);

	always #4 clk = ~clk;

	// Random back-pressure with about one stall in three
	always @(posedge clk) begin
		retire_ready <= ($urandom % 3) != 0;
	end

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("sim failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		string line;
		if (got !== exp) begin
			line = $sformatf("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
			stop_on_error(line);
		end
	endtask

	function automatic logic cond_holds(input logic [2:0] f3, input logic [4:0] a,
		input logic [4:0] b);
		logic result;
		case (f3)
			F3_BEQ: result = (a == b);
			F3_BNE: result = (a != b);
			F3_BLT: result = ($signed(a) < $signed(b));
			F3_BGE: result = ($signed(a) >= $signed(b));
			F3_BLTU: result = (a < b);
			F3_BGEU: result = (a >= b);
			default: result = 1'b0;
		endcase
		return result;
	endfunction

	// Architectural successor of one instruction
	function automatic addr_t next_pc(input addr_t pc, input inst_t inst);
		logic [31:0] imm_j;
		logic [31:0] imm_b;
		addr_t result;
		imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
		imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
		result = pc + 32'd4;
		if (inst[6:0] == OPC_JAL) begin
			result = pc + imm_j;
		end else if (inst[6:0] == OPC_BRANCH) begin
			if (cond_holds(inst[14:12], inst[19:15], inst[24:20])) begin
				result = pc + imm_b;
			end
		end
		return result;
	endfunction

	// Returns at the negedge before the edge that completes a handshake
	task automatic wait_for_retire();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!(retire_valid && retire_ready) && cycles < TIMEOUT_CYCLES) begin
			@(negedge clk);
			cycles++;
		end
		if (!(retire_valid && retire_ready)) begin
			stop_on_error("No retire handshake within 200 cycles");
		end
	endtask

	// Outputs must hold while the retire port is stalled
	always @(negedge clk) begin
		if (rst_n && stalled) begin
			check_value("retire_valid_o", {31'd0, retire_valid}, 32'd1);
			check_value("retire_pc_o", retire_pc, held_pc);
			check_value("retire_inst_o", retire_inst, held_inst);
		end
		stalled = rst_n && retire_valid && !retire_ready;
		held_pc = retire_pc;
		held_inst = retire_inst;
	end

	initial begin
		addr_t exp_pc;
		inst_t exp_inst;
		void'($urandom(32'h3c85));
		clk = 1'b0;
		rst_n = 1'b0;
		retire_ready = 1'b0;
		stalled = 1'b0;
		$readmemh("program.hex", prog);

		repeat (3) begin
			@(posedge clk);
			check_value("retire_valid_o", {31'd0, retire_valid}, 32'd0);
		end
		rst_n <= 1'b1;

		exp_pc = INIT_PC;
		for (int n = 0; n < RETIRE_COUNT; n++) begin
			wait_for_retire();
			exp_inst = prog[exp_pc[7:2]];
			check_value("retire_pc_o", retire_pc, exp_pc);
			check_value("retire_inst_o", retire_inst, exp_inst);
			exp_pc = next_pc(exp_pc, exp_inst);
		end

		@(negedge clk);
		$display("sim passed");
		$finish;
	end

endmodule

// ==== program.hex ====
// One 32-bit instruction word per line, word 0 at address 0
// Filler words 5, 6, 9, 10 and 22 sit on skipped paths
00000093
00100093
00200093
00300093
00C0006F // jal x0 to word 7
00500113
00600113
00700093
00000663 // beq x0,x0 forward taken
00900113
00A00113
00116463 // bltu x2,x1 forward not taken
00C00093
FE1FDCE3 // bge x31,x1 backward not taken
00E00093
00C000EF // jal x1 to word 18
01000093
00C002EF // jal x5 to word 20
01200093
FE1FFAE3 // bgeu x31,x1 backward taken to word 16
01400093
000FC463 // blt x31,x0 forward taken
01600113
01700093
FA1FF06F // jal x0 back to word 0

// ==== verilog.f ====
fetch_pkg.sv
apb_read_master.sv
imem_apb.sv
fetch_unit.sv
branch_resolver.sv
fetch_top.sv
tb_fetch.sv

// ==== Makefile ====
SIM      ?= verilator
SIMFLAGS ?= --binary --timing --assert
TOP      ?= tb_fetch
FILELIST ?= verilog.f

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with $(SIM) and run it"
	@echo "  clean  remove obj_dir"
	@echo "  help   show this list"

test:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
